/* rtl/local_sram.sv */
//====================
// Vector-wide scratchpad, one registered port
//====================
`timescale 1ns/10ps

module local_sram #(
	parameter DATA_BW = tau_cfg_pkg::DATA_BW,
	parameter VSIZE = tau_cfg_pkg::VSIZE,
	parameter LOCAL_ADDR_BW = tau_cfg_pkg::LOCAL_ADDR_BW
) (
	input  logic i_clk,
	input  logic i_en,
	input  logic i_we,
	input  logic [LOCAL_ADDR_BW-$clog2(VSIZE)-1:0] i_addr,
	input  logic [VSIZE*DATA_BW-1:0] i_wdata,
	output logic [VSIZE*DATA_BW-1:0] o_rdata
);

	localparam DEPTH = 2 ** (LOCAL_ADDR_BW - $clog2(VSIZE));

	logic [VSIZE*DATA_BW-1:0] mem [DEPTH];

	// A write leaves the last read data in place
	always_ff @(posedge i_clk) begin
		if (i_en) begin
			if (i_we) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

/* rtl/sram_port_arbiter.sv */
//====================
// Fixed-priority arbiter onto the single scratchpad port
//====================
`timescale 1ns/10ps

module sram_port_arbiter #(
	parameter DATA_BW = tau_cfg_pkg::DATA_BW,
	parameter VSIZE = tau_cfg_pkg::VSIZE,
	parameter LOCAL_ADDR_BW = tau_cfg_pkg::LOCAL_ADDR_BW
) (
	input  logic i_clk,
	input  logic i_rst,
	sram_req_if.arbiter i_hi,
	sram_req_if.arbiter i_lo,
	output logic o_en,
	output logic o_we,
	output logic [LOCAL_ADDR_BW-$clog2(VSIZE)-1:0] o_addr,
	output logic [VSIZE*DATA_BW-1:0] o_wdata,
	input  logic [VSIZE*DATA_BW-1:0] i_rdata
);

	//====================
	// Grant
	//====================
	// High side never waits
	assign i_hi.gnt = i_hi.req;
	assign i_lo.gnt = i_lo.req && !i_hi.req;

	//====================
	// Port mux
	//====================
	assign o_en = i_hi.req || i_lo.req;
	assign o_we = i_hi.req ? i_hi.we : (i_lo.req && i_lo.we);
	assign o_addr = i_hi.req ? i_hi.addr : i_lo.addr;
	assign o_wdata = i_hi.req ? i_hi.wdata : i_lo.wdata;

	// Each side knows from its own grant whether the data is meant for it
	assign i_hi.rdata = i_rdata;
	assign i_lo.rdata = i_rdata;

	a_single_grant: assert property (@(posedge i_clk) disable iff (!i_rst)
		!(i_hi.gnt && i_lo.gnt));

endmodule

/* rtl/sram_req_if.sv */
//====================
// One requester's access to the shared scratchpad port
//====================
`timescale 1ns/10ps

interface sram_req_if #(
	parameter ADDR_BW = 4,
	// Full vector width in bits
	parameter VEC_BW = 32
);

	// One-cycle access strobe
	logic req;
	logic we;
	logic [ADDR_BW-1:0] addr;
	logic [VEC_BW-1:0] wdata;
	// Grant, in the same cycle as req
	logic gnt;
	// Read data, one cycle after the grant
	logic [VEC_BW-1:0] rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

/* rtl/sram_vector_reader.sv */
//====================
// External vector reads through the shared scratchpad port
//====================
`timescale 1ns/10ps

module sram_vector_reader #(
	parameter DATA_BW = tau_cfg_pkg::DATA_BW,
	parameter VSIZE = tau_cfg_pkg::VSIZE,
	parameter LOCAL_ADDR_BW = tau_cfg_pkg::LOCAL_ADDR_BW
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_rd_rdy,
	output logic o_rd_ack,
	input  logic [LOCAL_ADDR_BW-$clog2(VSIZE)-1:0] i_rd_addr,
	output logic o_rd_dval,
	output logic [DATA_BW-1:0] o_rd_data [VSIZE],
	sram_req_if.requester o_rd
);

	logic dval_r;
	logic [DATA_BW-1:0] data_r [VSIZE];

	// Request stays up until the arbiter finds a free cycle
	assign o_rd.req = i_rd_rdy;
	assign o_rd.we = 1'b0;
	assign o_rd.addr = i_rd_addr;
	assign o_rd.wdata = '0;
	assign o_rd_ack = i_rd_rdy && o_rd.gnt;
	assign o_rd_dval = dval_r;

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			dval_r <= 1'b0;
		end else begin
			dval_r <= o_rd_ack;
		end
	end

	// Returned vector is held after the valid cycle
	always_ff @(posedge i_clk) begin
		if (dval_r) begin
			for (int i = 0; i < VSIZE; i++) begin
				data_r[i] <= o_rd.rdata[i*DATA_BW +: DATA_BW];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < VSIZE; i++) begin
			o_rd_data[i] = dval_r ? o_rd.rdata[i*DATA_BW +: DATA_BW] : data_r[i];
		end
	end

	a_dval_after_ack: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_rd_dval == $past(o_rd_ack));

endmodule

/* rtl/sram_write_collector.sv */
//====================
// Load allocation, command walk and burst word alignment
// Packs aligned words into vector writes and reports done
//====================
`timescale 1ns/10ps

module sram_write_collector #(
	parameter DATA_BW = tau_cfg_pkg::DATA_BW,
	parameter VSIZE = tau_cfg_pkg::VSIZE,
	parameter CSIZE = tau_cfg_pkg::CSIZE,
	parameter LOCAL_ADDR_BW = tau_cfg_pkg::LOCAL_ADDR_BW
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_alloc_rdy,
	output logic o_alloc_ack,
	input  logic [LOCAL_ADDR_BW-1:0] i_linear,
	input  logic [tau_cfg_pkg::ICFG_BW-1:0] i_linear_id,
	input  logic [LOCAL_ADDR_BW:0] i_sizes [tau_cfg_pkg::N_ICFG],
	input  logic i_cmd_rdy,
	output logic o_cmd_ack,
	input  logic [1:0] i_cmd_type,
	input  logic i_cmd_islast,
	input  logic [$clog2(CSIZE)-1:0] i_cmd_addrofs,
	input  logic [$clog2(VSIZE+1)-1:0] i_cmd_len,
	input  logic i_dramrd_rdy,
	output logic o_dramrd_ack,
	input  logic [DATA_BW-1:0] i_dramrd [CSIZE],
	output logic o_done_rdy,
	input  logic i_done_ack,
	output logic [LOCAL_ADDR_BW-1:0] o_linear,
	output logic [tau_cfg_pkg::ICFG_BW-1:0] o_linear_id,
	sram_req_if.requester o_wr
);

	localparam CV_BW = $clog2(VSIZE);
	localparam CV_BW1 = $clog2(VSIZE+1);
	localparam CC_BW = $clog2(CSIZE);
	localparam OFS_BW = CC_BW + CV_BW1;
	localparam WIDE_BW = (CSIZE + VSIZE) * DATA_BW;
	localparam logic [tau_cfg_pkg::COMMIT:0] ST_RESET = 1 << tau_cfg_pkg::FREE;

	logic [tau_cfg_pkg::COMMIT:0] state_r;
	logic [tau_cfg_pkg::COMMIT:0] state_w;
	logic [LOCAL_ADDR_BW-1:0] cur_r;
	logic [LOCAL_ADDR_BW-1:0] cur_w;
	logic [CV_BW1-1:0] handled_r;
	logic [CV_BW1-1:0] handled_w;
	logic [LOCAL_ADDR_BW:0] filled_r;
	logic [LOCAL_ADDR_BW:0] filled_w;
	logic [LOCAL_ADDR_BW:0] filled_nxt;
	logic [LOCAL_ADDR_BW:0] size_r;
	logic [CV_BW-1:0] pos;
	logic [CV_BW1-1:0] buf_left;
	logic [CV_BW1-1:0] cmd_left;
	logic [CV_BW1-1:0] seg_len;
	logic cmd_fits;
	logic vec_full;
	logic fill_done;
	logic need_burst;
	logic consume;
	logic vec_write;
	logic [CSIZE*DATA_BW-1:0] burst_flat;
	logic [WIDE_BW-1:0] burst_wide;
	logic [WIDE_BW-1:0] burst_shr;
	logic [WIDE_BW-1:0] burst_shl;
	logic [OFS_BW-1:0] src_ofs;
	logic [VSIZE-1:0] lane_mask;
	logic [DATA_BW-1:0] lane_data [VSIZE];
	logic [DATA_BW-1:0] vec_r [VSIZE];
	logic [LOCAL_ADDR_BW-CV_BW-1:0] hiaddr_r;
	logic req_r;

	//====================
	// Segment geometry
	//====================
	assign pos = cur_r[CV_BW-1:0];
	assign buf_left = CV_BW1'(VSIZE) - CV_BW1'(pos);
	assign cmd_left = i_cmd_len - handled_r;
	assign cmd_fits = cmd_left <= buf_left;
	assign vec_full = cmd_left >= buf_left;
	assign seg_len = cmd_fits ? cmd_left : buf_left;
	assign filled_nxt = filled_r + (LOCAL_ADDR_BW+1)'(seg_len);
	assign fill_done = filled_nxt == size_r;

	// Zero-fill needs the burst only to release it on the last command
	assign need_burst = i_cmd_islast || (i_cmd_type != tau_cfg_pkg::CMD_ZERO);
	assign consume = state_r[tau_cfg_pkg::RUN] && i_cmd_rdy && (!need_burst || i_dramrd_rdy);
	// A partial vector at the end of the load is flushed as well
	assign vec_write = consume && (vec_full || fill_done);
	assign lane_mask = ~({VSIZE{1'b1}} << seg_len) << pos;

	assign o_done_rdy = state_r[tau_cfg_pkg::COMMIT];

	//====================
	// FSM
	//====================
	always_comb begin
		state_w = '0;
		o_alloc_ack = 1'b0;
		o_cmd_ack = 1'b0;
		o_dramrd_ack = 1'b0;
		cur_w = cur_r;
		handled_w = handled_r;
		filled_w = filled_r;
		unique case (1'b1)
			state_r[tau_cfg_pkg::FREE]: begin
				if (i_alloc_rdy) begin
					o_alloc_ack = 1'b1;
					cur_w = i_linear;
					handled_w = '0;
					filled_w = '0;
					state_w[tau_cfg_pkg::RUN] = 1'b1;
				end else begin
					state_w[tau_cfg_pkg::FREE] = 1'b1;
				end
			end
			state_r[tau_cfg_pkg::RUN]: begin
				if (consume) begin
					cur_w = cur_r + LOCAL_ADDR_BW'(seg_len);
					o_cmd_ack = cmd_fits;
					handled_w = cmd_fits ? '0 : handled_r + seg_len;
					o_dramrd_ack = cmd_fits && i_cmd_islast;
					filled_w = filled_nxt;
					if (fill_done) begin
						state_w[tau_cfg_pkg::COMMIT] = 1'b1;
					end else begin
						state_w[tau_cfg_pkg::RUN] = 1'b1;
					end
				end else begin
					state_w[tau_cfg_pkg::RUN] = 1'b1;
				end
			end
			state_r[tau_cfg_pkg::COMMIT]: begin
				if (i_done_ack) begin
					state_w[tau_cfg_pkg::FREE] = 1'b1;
				end else begin
					state_w[tau_cfg_pkg::COMMIT] = 1'b1;
				end
			end
			default: begin
				state_w[tau_cfg_pkg::FREE] = 1'b1;
			end
		endcase
	end

	//====================
	// Word alignment
	//====================
	always_comb begin
		for (int i = 0; i < CSIZE; i++) begin
			burst_flat[i*DATA_BW +: DATA_BW] = i_dramrd[i];
		end
		burst_wide = {{(VSIZE*DATA_BW){1'b0}}, burst_flat};
		src_ofs = OFS_BW'(i_cmd_addrofs) + OFS_BW'(handled_r);
		// Source word to lane 0, then up to the vector position
		burst_shr = burst_wide >> (src_ofs * DATA_BW);
		burst_shl = burst_shr << (pos * DATA_BW);
		for (int i = 0; i < VSIZE; i++) begin
			case (i_cmd_type)
				tau_cfg_pkg::CMD_COPY: lane_data[i] = burst_shl[i*DATA_BW +: DATA_BW];
				tau_cfg_pkg::CMD_BCAST: lane_data[i] = i_dramrd[i_cmd_addrofs];
				default: lane_data[i] = '0;
			endcase
		end
	end

	always_comb begin
		for (int i = 0; i < VSIZE; i++) begin
			o_wr.wdata[i*DATA_BW +: DATA_BW] = vec_r[i];
		end
	end

	assign o_wr.req = req_r;
	assign o_wr.we = 1'b1;
	assign o_wr.addr = hiaddr_r;

	//====================
	// Registers
	//====================
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state_r <= ST_RESET;
			cur_r <= '0;
			handled_r <= '0;
			filled_r <= '0;
			req_r <= 1'b0;
		end else begin
			state_r <= state_w;
			cur_r <= cur_w;
			handled_r <= handled_w;
			filled_r <= filled_w;
			req_r <= vec_write;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			size_r <= '0;
			o_linear <= '0;
			o_linear_id <= '0;
		end else if (o_alloc_ack) begin
			size_r <= i_sizes[i_linear_id];
			o_linear <= i_linear;
			o_linear_id <= i_linear_id;
		end
	end

	// Lanes not written after a vector goes out start again from zero
	always_ff @(posedge i_clk) begin
		if (vec_write) begin
			hiaddr_r <= cur_r[LOCAL_ADDR_BW-1:CV_BW];
		end
		for (int i = 0; i < VSIZE; i++) begin
			if (consume && lane_mask[i]) begin
				vec_r[i] <= lane_data[i];
			end else if (req_r || o_alloc_ack) begin
				vec_r[i] <= '0;
			end
		end
	end

	a_state_onehot: assert property (@(posedge i_clk) disable iff (!i_rst)
		$onehot(state_r));
	a_cmd_ack_in_run: assert property (@(posedge i_clk) disable iff (!i_rst)
		o_cmd_ack |-> state_r[tau_cfg_pkg::RUN]);

endmodule

/* rtl/tau_cfg_pkg.sv */
//====================
// Shared geometry defaults, command codes and collector states
//====================
package tau_cfg_pkg;

	//====================
	// Geometry defaults
	//====================
	// Bits per data word
	localparam int DATA_BW = 8;
	// Words per scratchpad vector
	localparam int VSIZE = 4;
	// Words per DRAM burst
	localparam int CSIZE = 4;
	// Word-granular local address width
	localparam int LOCAL_ADDR_BW = 6;
	// Entries in the load size table
	localparam int N_ICFG = 2;
	localparam int ICFG_BW = $clog2(N_ICFG);

	//====================
	// Codes
	//====================
	typedef enum logic [1:0] {
		CMD_COPY  = 2'd0,
		CMD_BCAST = 2'd1,
		CMD_ZERO  = 2'd2
	} cmd_type_e;

	// Bit positions of the one-hot collector state vector
	typedef enum int {FREE = 0, RUN = 1, COMMIT = 2} collector_state_e;

endpackage

/* rtl/tensor_load_unit.sv */
//====================
// Tensor load unit top level
// Collector and reader share the scratchpad through the arbiter
//====================
`timescale 1ns/10ps

module tensor_load_unit #(
	parameter DATA_BW = tau_cfg_pkg::DATA_BW,
	parameter VSIZE = tau_cfg_pkg::VSIZE,
	parameter CSIZE = tau_cfg_pkg::CSIZE,
	parameter LOCAL_ADDR_BW = tau_cfg_pkg::LOCAL_ADDR_BW
) (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_alloc_rdy,
	output logic o_alloc_ack,
	input  logic [LOCAL_ADDR_BW-1:0] i_linear,
	input  logic [tau_cfg_pkg::ICFG_BW-1:0] i_linear_id,
	input  logic [LOCAL_ADDR_BW:0] i_sizes [tau_cfg_pkg::N_ICFG],
	input  logic i_cmd_rdy,
	output logic o_cmd_ack,
	input  logic [1:0] i_cmd_type,
	input  logic i_cmd_islast,
	input  logic [$clog2(CSIZE)-1:0] i_cmd_addrofs,
	input  logic [$clog2(VSIZE+1)-1:0] i_cmd_len,
	input  logic i_dramrd_rdy,
	output logic o_dramrd_ack,
	input  logic [DATA_BW-1:0] i_dramrd [CSIZE],
	output logic o_done_rdy,
	input  logic i_done_ack,
	output logic [LOCAL_ADDR_BW-1:0] o_linear,
	output logic [tau_cfg_pkg::ICFG_BW-1:0] o_linear_id,
	input  logic i_rd_rdy,
	output logic o_rd_ack,
	input  logic [LOCAL_ADDR_BW-$clog2(VSIZE)-1:0] i_rd_addr,
	output logic o_rd_dval,
	output logic [DATA_BW-1:0] o_rd_data [VSIZE]
);

	localparam VA_BW = LOCAL_ADDR_BW - $clog2(VSIZE);
	localparam VEC_BW = VSIZE * DATA_BW;

	logic sram_en;
	logic sram_we;
	logic [VA_BW-1:0] sram_addr;
	logic [VEC_BW-1:0] sram_wdata;
	logic [VEC_BW-1:0] sram_rdata;

	sram_req_if #(.ADDR_BW(VA_BW), .VEC_BW(VEC_BW)) wr_if ();
	sram_req_if #(.ADDR_BW(VA_BW), .VEC_BW(VEC_BW)) rd_if ();

	sram_write_collector #(
		.DATA_BW(DATA_BW),
		.VSIZE(VSIZE),
		.CSIZE(CSIZE),
		.LOCAL_ADDR_BW(LOCAL_ADDR_BW)
	) u_collector (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_alloc_rdy(i_alloc_rdy),
		.o_alloc_ack(o_alloc_ack),
		.i_linear(i_linear),
		.i_linear_id(i_linear_id),
		.i_sizes(i_sizes),
		.i_cmd_rdy(i_cmd_rdy),
		.o_cmd_ack(o_cmd_ack),
		.i_cmd_type(i_cmd_type),
		.i_cmd_islast(i_cmd_islast),
		.i_cmd_addrofs(i_cmd_addrofs),
		.i_cmd_len(i_cmd_len),
		.i_dramrd_rdy(i_dramrd_rdy),
		.o_dramrd_ack(o_dramrd_ack),
		.i_dramrd(i_dramrd),
		.o_done_rdy(o_done_rdy),
		.i_done_ack(i_done_ack),
		.o_linear(o_linear),
		.o_linear_id(o_linear_id),
		.o_wr(wr_if)
	);

	sram_vector_reader #(
		.DATA_BW(DATA_BW),
		.VSIZE(VSIZE),
		.LOCAL_ADDR_BW(LOCAL_ADDR_BW)
	) u_reader (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_rd_rdy(i_rd_rdy),
		.o_rd_ack(o_rd_ack),
		.i_rd_addr(i_rd_addr),
		.o_rd_dval(o_rd_dval),
		.o_rd_data(o_rd_data),
		.o_rd(rd_if)
	);

	// Collector on the high side, reader waits for idle cycles
	sram_port_arbiter #(
		.DATA_BW(DATA_BW),
		.VSIZE(VSIZE),
		.LOCAL_ADDR_BW(LOCAL_ADDR_BW)
	) u_arbiter (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_hi(wr_if),
		.i_lo(rd_if),
		.o_en(sram_en),
		.o_we(sram_we),
		.o_addr(sram_addr),
		.o_wdata(sram_wdata),
		.i_rdata(sram_rdata)
	);

	local_sram #(
		.DATA_BW(DATA_BW),
		.VSIZE(VSIZE),
		.LOCAL_ADDR_BW(LOCAL_ADDR_BW)
	) u_sram (
		.i_clk(i_clk),
		.i_en(sram_en),
		.i_we(sram_we),
		.i_addr(sram_addr),
		.i_wdata(sram_wdata),
		.o_rdata(sram_rdata)
	);

endmodule

/* tensor_load_unit.f */
rtl/tau_cfg_pkg.sv
rtl/sram_req_if.sv
rtl/local_sram.sv
rtl/sram_port_arbiter.sv
rtl/sram_vector_reader.sv
rtl/sram_write_collector.sv
rtl/tensor_load_unit.sv
verification/tb_tensor_load_unit.sv

/* verification/tb_tensor_load_unit.sv */
//====================
// Testbench for the tensor load unit
// Shadow scratchpad model, read-back comparison and report
//====================
`timescale 1ns/10ps

module tb_tensor_load_unit;

	localparam int DATA_BW = tau_cfg_pkg::DATA_BW;
	localparam int VSIZE = tau_cfg_pkg::VSIZE;
	localparam int CSIZE = tau_cfg_pkg::CSIZE;
	localparam int LA_BW = tau_cfg_pkg::LOCAL_ADDR_BW;
	localparam int ID_BW = tau_cfg_pkg::ICFG_BW;
	localparam int VA_BW = LA_BW - $clog2(VSIZE);
	localparam int VEC_BW = VSIZE * DATA_BW;
	localparam int DEPTH = 2 ** VA_BW;
	localparam int OFS_BW = $clog2(CSIZE);
	localparam int LEN_BW = $clog2(VSIZE + 1);
	// All tests together run a few hundred cycles
	localparam int MAX_CYCLES = 4000;

	logic i_clk;
	logic i_rst;
	logic i_alloc_rdy;
	logic o_alloc_ack;
	logic [LA_BW-1:0] i_linear;
	logic [ID_BW-1:0] i_linear_id;
	logic [LA_BW:0] i_sizes [tau_cfg_pkg::N_ICFG];
	logic i_cmd_rdy;
	logic o_cmd_ack;
	logic [1:0] i_cmd_type;
	logic i_cmd_islast;
	logic [OFS_BW-1:0] i_cmd_addrofs;
	logic [LEN_BW-1:0] i_cmd_len;
	logic i_dramrd_rdy;
	logic o_dramrd_ack;
	logic [DATA_BW-1:0] i_dramrd [CSIZE];
	logic o_done_rdy;
	logic i_done_ack;
	logic [LA_BW-1:0] o_linear;
	logic [ID_BW-1:0] o_linear_id;
	logic i_rd_rdy;
	logic o_rd_ack;
	logic [VA_BW-1:0] i_rd_addr;
	logic o_rd_dval;
	logic [DATA_BW-1:0] o_rd_data [VSIZE];

	// Shadow scratchpad and the vector being collected
	logic [VEC_BW-1:0] shadow [DEPTH];
	logic [DATA_BW-1:0] lane_buf [VSIZE];
	int m_cur;
	int m_filled;
	int m_size;

	logic [VEC_BW-1:0] exp_q [$];
	int addr_q [$];
	logic ack_d = 1'b0;
	int errors = 0;
	int test_num = 0;
	int test_base = 0;
	int reads_checked = 0;
	int stalls = 0;
	int cycles = 0;
	bit load_busy = 1'b0;
	int old_vecs [5] = '{0, 1, 4, 5, 6};
	int unsigned seed = 75105;

	tensor_load_unit #(
		.DATA_BW(DATA_BW),
		.VSIZE(VSIZE),
		.CSIZE(CSIZE),
		.LOCAL_ADDR_BW(LA_BW)
	) i_dut (
		.i_clk(i_clk),
		.i_rst(i_rst),
		.i_alloc_rdy(i_alloc_rdy),
		.o_alloc_ack(o_alloc_ack),
		.i_linear(i_linear),
		.i_linear_id(i_linear_id),
		.i_sizes(i_sizes),
		.i_cmd_rdy(i_cmd_rdy),
		.o_cmd_ack(o_cmd_ack),
		.i_cmd_type(i_cmd_type),
		.i_cmd_islast(i_cmd_islast),
		.i_cmd_addrofs(i_cmd_addrofs),
		.i_cmd_len(i_cmd_len),
		.i_dramrd_rdy(i_dramrd_rdy),
		.o_dramrd_ack(o_dramrd_ack),
		.i_dramrd(i_dramrd),
		.o_done_rdy(o_done_rdy),
		.i_done_ack(i_done_ack),
		.o_linear(o_linear),
		.o_linear_id(o_linear_id),
		.i_rd_rdy(i_rd_rdy),
		.o_rd_ack(o_rd_ack),
		.i_rd_addr(i_rd_addr),
		.o_rd_dval(o_rd_dval),
		.o_rd_data(o_rd_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge i_clk);
			cycles++;
		end
		$display("Timeout after %0d cycles, a handshake never completed", cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [31:0] want,
			input logic [31:0] got);
		$display("FAILED %s expected %h got %h", name, want, got);
		errors++;
	endtask

	task automatic report_test(input string name);
		$display("test %0d %s: %0d errors", test_num, name, errors - test_base);
		test_num++;
		test_base = errors;
	endtask

	//====================
	// Reference model
	//====================
	function automatic void start_shadow_load(input int linear, input int size);
		m_cur = linear;
		m_filled = 0;
		m_size = size;
		for (int i = 0; i < VSIZE; i++) begin
			lane_buf[i] = '0;
		end
	endfunction

	// One word per step; a vector goes out when full or when the load ends
	function automatic void apply_command_rules(input logic [1:0] ctype, input int ofs,
			input int len);
		int lane;
		int vaddr;
		logic [DATA_BW-1:0] word;
		for (int k = 0; k < len; k++) begin
			if (ctype == tau_cfg_pkg::CMD_COPY) begin
				word = (ofs + k < CSIZE) ? i_dramrd[ofs + k] : '0;
			end else if (ctype == tau_cfg_pkg::CMD_BCAST) begin
				word = i_dramrd[ofs];
			end else begin
				word = '0;
			end
			lane = m_cur % VSIZE;
			vaddr = m_cur / VSIZE;
			lane_buf[lane] = word;
			m_cur = (m_cur + 1) % (2 ** LA_BW);
			m_filled++;
			if (lane == VSIZE - 1 || m_filled == m_size) begin
				for (int i = 0; i < VSIZE; i++) begin
					shadow[vaddr][i*DATA_BW +: DATA_BW] = lane_buf[i];
					lane_buf[i] = '0;
				end
			end
		end
	endfunction

	//====================
	// Stimulus tasks
	//====================
	// Called at a falling edge while no burst is pending
	task automatic load_burst();
		for (int i = 0; i < CSIZE; i++) begin
			i_dramrd[i] = DATA_BW'($urandom);
		end
	endtask

	task automatic allocate(input int linear, input int id, input int size);
		bit acked;
		@(negedge i_clk);
		i_sizes[id] = (LA_BW+1)'(size);
		i_linear = LA_BW'(linear);
		i_linear_id = ID_BW'(id);
		i_alloc_rdy = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(posedge i_clk);
			acked = o_alloc_ack;
		end
		start_shadow_load(linear, size);
		@(negedge i_clk);
		i_alloc_rdy = 1'b0;
	endtask

	task automatic send_command(input logic [1:0] ctype, input logic islast, input int ofs,
			input int len);
		bit acked;
		@(negedge i_clk);
		i_cmd_type = ctype;
		i_cmd_islast = islast;
		i_cmd_addrofs = OFS_BW'(ofs);
		i_cmd_len = LEN_BW'(len);
		i_cmd_rdy = 1'b1;
		// Zero-fill gets no burst unless it closes the burst
		i_dramrd_rdy = islast || (ctype != tau_cfg_pkg::CMD_ZERO);
		acked = 1'b0;
		while (!acked) begin
			@(posedge i_clk);
			acked = o_cmd_ack;
			if (o_dramrd_ack !== (acked && islast)) begin
				report_mismatch("o_dramrd_ack", acked && islast, o_dramrd_ack);
			end
		end
		apply_command_rules(ctype, ofs, len);
		@(negedge i_clk);
		i_cmd_rdy = 1'b0;
		i_dramrd_rdy = 1'b0;
	endtask

	task automatic complete_load(input int hold, input int linear, input int id);
		do @(posedge i_clk); while (!o_done_rdy);
		if (hold > 0) begin
			@(negedge i_clk);
			i_alloc_rdy = 1'b1;
			i_linear = ~i_linear;
			repeat (hold) begin
				@(posedge i_clk);
				if (o_done_rdy !== 1'b1) begin
					report_mismatch("o_done_rdy", 1, o_done_rdy);
				end
				if (o_alloc_ack !== 1'b0) begin
					report_mismatch("o_alloc_ack", 0, o_alloc_ack);
				end
			end
		end
		@(negedge i_clk);
		i_alloc_rdy = 1'b0;
		i_done_ack = 1'b1;
		@(posedge i_clk);
		if (o_done_rdy !== 1'b1) begin
			report_mismatch("o_done_rdy", 1, o_done_rdy);
		end
		if (o_linear !== LA_BW'(linear)) begin
			report_mismatch("o_linear", linear, o_linear);
		end
		if (o_linear_id !== ID_BW'(id)) begin
			report_mismatch("o_linear_id", id, o_linear_id);
		end
		@(negedge i_clk);
		i_done_ack = 1'b0;
		@(posedge i_clk);
		if (o_done_rdy !== 1'b0) begin
			report_mismatch("o_done_rdy", 0, o_done_rdy);
		end
	endtask

	// Request stays up between reads so that back-to-back reads compete
	task automatic read_vector(input int vaddr);
		bit acked;
		@(negedge i_clk);
		i_rd_addr = VA_BW'(vaddr);
		i_rd_rdy = 1'b1;
		acked = 1'b0;
		while (!acked) begin
			@(posedge i_clk);
			acked = o_rd_ack;
		end
		exp_q.push_back(shadow[vaddr]);
		addr_q.push_back(vaddr);
	endtask

	task automatic finish_reads();
		@(negedge i_clk);
		i_rd_rdy = 1'b0;
		repeat (2) @(posedge i_clk);
		if (exp_q.size() != 0) begin
			$display("A read was acknowledged but its data never came back");
			errors++;
		end
	endtask

	//====================
	// Read-back comparison
	//====================
	always @(posedge i_clk) begin
		logic [VEC_BW-1:0] want;
		int vaddr;
		if (i_rst) begin
			if (o_rd_dval !== ack_d) begin
				report_mismatch("o_rd_dval", ack_d, o_rd_dval);
			end
			if (o_rd_dval === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("Read data came back with no read outstanding");
					errors++;
				end else begin
					want = exp_q.pop_front();
					vaddr = addr_q.pop_front();
					for (int i = 0; i < VSIZE; i++) begin
						if (o_rd_data[i] !== want[i*DATA_BW +: DATA_BW]) begin
							report_mismatch($sformatf("o_rd_data[%0d] of vector %0d", i, vaddr),
								want[i*DATA_BW +: DATA_BW], o_rd_data[i]);
						end
					end
					reads_checked++;
				end
			end
			if (i_rd_rdy && !o_rd_ack) begin
				stalls++;
			end
			ack_d = o_rd_ack;
		end
	end

	//====================
	// Test sequence
	//====================
	initial begin
		int k;
		void'($urandom(seed));
		i_rst = 1'b0;
		i_alloc_rdy = 1'b0;
		i_linear = '0;
		i_linear_id = '0;
		i_sizes[0] = '0;
		i_sizes[1] = '0;
		i_cmd_rdy = 1'b0;
		i_cmd_type = '0;
		i_cmd_islast = 1'b0;
		i_cmd_addrofs = '0;
		i_cmd_len = '0;
		i_dramrd_rdy = 1'b0;
		for (int i = 0; i < CSIZE; i++) begin
			i_dramrd[i] = '0;
		end
		i_done_ack = 1'b0;
		i_rd_rdy = 1'b0;
		i_rd_addr = '0;
		repeat (10) @(posedge i_clk);
		@(negedge i_clk);
		i_rst = 1'b1;
		@(posedge i_clk);
		if ({o_alloc_ack, o_cmd_ack, o_dramrd_ack, o_done_rdy, o_rd_ack, o_rd_dval} !== '0) begin
			report_mismatch("handshake outputs after reset", 0,
				{o_alloc_ack, o_cmd_ack, o_dramrd_ack, o_done_rdy, o_rd_ack, o_rd_dval});
		end
		report_test("reset state");

		// Two full bursts into vectors 0 and 1
		allocate(0, 0, 8);
		load_burst();
		send_command(tau_cfg_pkg::CMD_COPY, 1'b1, 0, 4);
		load_burst();
		send_command(tau_cfg_pkg::CMD_COPY, 1'b1, 0, 4);
		complete_load(0, 0, 0);
		read_vector(0);
		read_vector(1);
		finish_reads();
		report_test("aligned copy");

		// Starts at lane 2 of vector 4 and runs into vector 5
		allocate(18, 1, 3);
		load_burst();
		send_command(tau_cfg_pkg::CMD_COPY, 1'b1, 1, 3);
		complete_load(0, 18, 1);
		read_vector(4);
		read_vector(5);
		finish_reads();
		report_test("unaligned copy");

		allocate(24, 0, 4);
		load_burst();
		send_command(tau_cfg_pkg::CMD_COPY, 1'b0, 0, 1);
		send_command(tau_cfg_pkg::CMD_BCAST, 1'b1, 3, 3);
		complete_load(0, 24, 0);
		read_vector(6);
		finish_reads();
		report_test("broadcast");

		allocate(32, 1, 8);
		send_command(tau_cfg_pkg::CMD_ZERO, 1'b0, 0, 4);
		send_command(tau_cfg_pkg::CMD_ZERO, 1'b0, 0, 3);
		load_burst();
		send_command(tau_cfg_pkg::CMD_ZERO, 1'b1, 0, 1);
		complete_load(0, 32, 1);
		read_vector(8);
		read_vector(9);
		finish_reads();
		report_test("zero fill");

		allocate(40, 1, 4);
		load_burst();
		send_command(tau_cfg_pkg::CMD_COPY, 1'b1, 0, 4);
		complete_load(6, 40, 1);
		read_vector(10);
		finish_reads();
		report_test("held done handshake");

		// Reads of earlier vectors run alongside a load into vectors 12 and 13
		stalls = 0;
		load_busy = 1'b1;
		k = 0;
		fork
			begin
				allocate(48, 0, 8);
				load_burst();
				send_command(tau_cfg_pkg::CMD_COPY, 1'b1, 0, 4);
				load_burst();
				send_command(tau_cfg_pkg::CMD_COPY, 1'b0, 2, 2);
				send_command(tau_cfg_pkg::CMD_BCAST, 1'b1, 0, 2);
				complete_load(0, 48, 0);
				load_busy = 1'b0;
			end
			begin
				while (load_busy) begin
					read_vector(old_vecs[k % 5]);
					k++;
				end
			end
		join
		read_vector(12);
		read_vector(13);
		finish_reads();
		if (stalls == 0) begin
			$display("The reader was never held off by a vector write during the load");
			errors++;
		end
		report_test("reads during load");

		$display("tests %0d, reads compared %0d, errors %0d", test_num, reads_checked, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
